/* project.f */
design/battle_pkg.sv
design/unit_roster.sv
design/battle_referee.sv
design/treasury.sv
design/wave_scheduler.sv
design/game_engine.sv
tb/engine_checker.sv
tb/tb_game_engine.sv

/* Bender.yml */
package:
  name: game_engine

sources:
  - design/battle_pkg.sv
  - design/unit_roster.sv
  - design/battle_referee.sv
  - design/treasury.sv
  - design/wave_scheduler.sv
  - design/game_engine.sv
  - target: test
    files:
      - tb/engine_checker.sv
      - tb/tb_game_engine.sv

/* tb/tb_game_engine.sv */
`timescale 1ns/100ps

module tb_game_engine;
    import battle_pkg::*;

    localparam int TICK_GAP     = 24;
    localparam int MAX_BUYS     = 8;
    localparam int SHOP_TICKS   = 80;
    localparam int HIT_TIMEOUT  = 300;    // in ticks
    localparam int LOSE_TIMEOUT = 1000;

    logic         clk_25MHz = 1'b0;
    logic         rst, start, tick, buy, upgrade;
    unit_kind_t   buy_kind;
    money_t       money;
    purse_level_t purse_level;
    logic         can_upgrade, game_win, game_lose;
    hp_t          tower_hp_enemy, tower_hp_army;
    int           fail_count, test_count;
    int           buys_made, stall_fails, waited;
    int           seed = 32'hcae9_0513;

    always #20 clk_25MHz = ~clk_25MHz;

    game_engine #(.NUM_SLOTS(8)) dut0 (
        .clk_25MHz, .rst, .start, .tick, .buy, .buy_kind, .upgrade,
        .money, .purse_level, .can_upgrade, .tower_hp_enemy, .tower_hp_army,
        .game_win, .game_lose
    );

    engine_checker chk0 (
        .clk_25MHz, .rst, .start, .tick, .buy, .buy_kind, .upgrade,
        .money, .purse_level, .can_upgrade, .tower_hp_enemy, .tower_hp_army,
        .game_win, .game_lose, .fail_count, .test_count
    );

    task automatic next_cycle();
        @(posedge clk_25MHz);
        #2;
    endtask

    // one tick, then the quiet cycles up to the next one
    task automatic play_tick(input bit shop);
        int buy_at;
        int up_at;
        buy_at = 0;
        up_at  = 0;
        if (shop && buys_made < MAX_BUYS && $urandom_range(3, 0) == 0)
            buy_at = $urandom_range(20, 2);
        if (shop && $urandom_range(2, 0) == 0)
            up_at = $urandom_range(21, 3);
        tick = 1'b1;
        next_cycle();
        tick = 1'b0;
        for (int i = 1; i < TICK_GAP; i++) begin
            if (i == buy_at) begin
                buy      = 1'b1;
                buy_kind = unit_kind_t'($urandom_range(3, 0));
                buys_made++;
            end
            upgrade = (i == up_at);
            next_cycle();
            buy     = 1'b0;
            upgrade = 1'b0;
        end
    endtask

    task automatic pulse_start();
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        repeat (2) next_cycle();
    endtask

    initial begin
        rst         = 1'b1;
        start       = 1'b0;
        tick        = 1'b0;
        buy         = 1'b0;
        buy_kind    = '0;
        upgrade     = 1'b0;
        buys_made   = 0;
        stall_fails = 0;
        void'($urandom(seed));
        repeat (10) next_cycle();
        rst = 1'b0;
        next_cycle();

        repeat (SHOP_TICKS) play_tick(1'b1);
        pulse_start();

        // --------------------------------------------------
        // no purchases, the wave alone has to break through
        waited = 0;
        while (tower_hp_army == TOWER_HP_INIT && waited < HIT_TIMEOUT) begin
            play_tick(1'b0);
            waited++;
        end
        if (tower_hp_army == TOWER_HP_INIT) begin
            $display("timeout: army tower took no damage within %0d ticks", HIT_TIMEOUT);
            stall_fails++;
        end
        waited = 0;
        while (!game_lose && waited < LOSE_TIMEOUT) begin
            play_tick(1'b0);
            waited++;
        end
        if (!game_lose) begin
            $display("timeout: game_lose never rose within %0d ticks", LOSE_TIMEOUT);
            stall_fails++;
        end

        repeat (3) play_tick(1'b1);   // frozen game, shop pulses too
        pulse_start();

        $display("%0d tests, %0d errors", test_count, fail_count + stall_fails);
        if (fail_count == 0 && stall_fails == 0 && test_count > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* tb/engine_checker.sv */
`timescale 1ns/100ps

module engine_checker (
    input  logic                     clk_25MHz,
    input  logic                     rst,
    input  logic                     start,
    input  logic                     tick,
    input  logic                     buy,
    input  battle_pkg::unit_kind_t   buy_kind,
    input  logic                     upgrade,
    input  battle_pkg::money_t       money,
    input  battle_pkg::purse_level_t purse_level,
    input  logic                     can_upgrade,
    input  battle_pkg::hp_t          tower_hp_enemy,
    input  battle_pkg::hp_t          tower_hp_army,
    input  logic                     game_win,
    input  logic                     game_lose,
    output int                       fail_count,
    output int                       test_count
);
    import battle_pkg::*;

    typedef struct packed {
        money_t       money;
        purse_level_t level;
    } purse_t;

    purse_t     mdl;                  // expected treasury state
    logic       buy_req, up_req;
    unit_kind_t req_kind;
    logic       fresh, tick_seen, frozen_seen;
    hp_t        last_enemy, last_army, frozen_enemy, frozen_army;
    int         tick_num, errs_at_tick, errs_at_frozen;

    // purchase, then upgrade, then income capped at the new level's max
    function automatic purse_t treasury_step(input purse_t cur, input logic want_buy,
                                             input unit_kind_t kind, input logic want_up);
        purse_t nxt;
        int     coins;
        coins = int'(cur.money);
        nxt.level = cur.level;
        if (want_buy && coins >= int'(army_cost(kind)))
            coins = coins - int'(army_cost(kind));  // lane never full, at most eight buys
        if (want_up && cur.level < 3'd7 && coins >= int'(purse_need(cur.level))) begin
            coins = coins - int'(purse_need(cur.level));
            nxt.level = cur.level + 3'd1;
        end
        coins = coins + int'(purse_income(nxt.level));
        if (coins > int'(purse_max(nxt.level)))
            coins = int'(purse_max(nxt.level));
        nxt.money = money_t'(coins);
        return nxt;
    endfunction

    task automatic report_error(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        fail_count++;
    endtask

    task automatic close_test(input string name, input int errs_before);
        test_count++;
        $display("%s: %s", name, (fail_count == errs_before) ? "pass" : "FAIL");
    endtask

    initial begin
        fail_count = 0;
        test_count = 0;
        tick_num   = 0;
    end

    // --------------------------------------------------
    // values read here are the ones held before this edge
    always @(posedge clk_25MHz) begin : watch
        logic accepted;
        int   errs_before;
        if (rst || start) begin
            if (frozen_seen)
                close_test("tick after game over", errs_at_frozen);
            mdl         = '0;
            buy_req     = 1'b0;
            up_req      = 1'b0;
            fresh       = 1'b1;
            tick_seen   = 1'b0;
            frozen_seen = 1'b0;
        end else begin
            errs_before = fail_count;
            if (money != mdl.money || purse_level != mdl.level)
                report_error($sformatf("money %0d level %0d, expected money %0d level %0d",
                                       money, purse_level, mdl.money, mdl.level));
            if (can_upgrade != (mdl.money >= purse_need(mdl.level)))
                report_error($sformatf("can_upgrade is %0b with money %0d", can_upgrade, money));
            if (game_win != (tower_hp_enemy == '0) || game_lose != (tower_hp_army == '0))
                report_error($sformatf("win %0b lose %0b with towers %0d / %0d",
                                       game_win, game_lose, tower_hp_enemy, tower_hp_army));
            if (fresh) begin
                if (tower_hp_enemy != TOWER_HP_INIT || tower_hp_army != TOWER_HP_INIT)
                    report_error($sformatf("towers %0d / %0d after restart",
                                           tower_hp_enemy, tower_hp_army));
                close_test("state after reset or start", errs_before);
                fresh = 1'b0;
            end else if (tower_hp_enemy > last_enemy || tower_hp_army > last_army) begin
                report_error("a tower gained hit points");
            end
            if (tick_seen)
                close_test($sformatf("tick %0d, money %0d level %0d", tick_num, money,
                                     purse_level), errs_at_tick);
            // towers stay put from the first ignored tick until start
            if (frozen_seen &&
                    (tower_hp_enemy != frozen_enemy || tower_hp_army != frozen_army))
                report_error("tower hit points changed after the game ended");

            accepted = tick && !game_win && !game_lose;
            tick_seen = accepted;
            if (accepted) begin
                mdl = treasury_step(mdl, buy_req, req_kind, up_req);
                tick_num++;
                errs_at_tick = fail_count;
            end
            if (tick && !accepted) begin
                if (frozen_seen) begin
                    close_test("tick after game over", errs_at_frozen);
                end else begin
                    frozen_enemy = tower_hp_enemy;
                    frozen_army  = tower_hp_army;
                end
                frozen_seen    = 1'b1;
                errs_at_frozen = fail_count;
            end
            buy_req = buy || (buy_req && !accepted);
            up_req  = upgrade || (up_req && !accepted);
            if (buy)
                req_kind = buy_kind;
            last_enemy = tower_hp_enemy;
            last_army  = tower_hp_army;
        end
    end

endmodule

/* design/game_engine.sv */
`timescale 1ns/100ps

module game_engine #(
    parameter int NUM_SLOTS = 8
) (
    input  logic                      clk_25MHz,
    input  logic                      rst,
    input  logic                      start,
    input  logic                      tick,
    input  logic                      buy,
    input  battle_pkg::unit_kind_t    buy_kind,
    input  logic                      upgrade,
    output battle_pkg::money_t        money,
    output battle_pkg::purse_level_t  purse_level,
    output logic                      can_upgrade,
    output battle_pkg::hp_t           tower_hp_enemy,
    output battle_pkg::hp_t           tower_hp_army,
    output logic                      game_win,
    output logic                      game_lose
);
    import battle_pkg::*;

    logic       tick_ok, scan_start, hit_apply;
    logic       enemy_done, army_done;
    strike_t    enemy_strikes, army_strikes;
    pos_t       enemy_front_pos, army_front_pos;
    logic       enemy_front_valid, army_front_valid;
    logic       enemy_space, army_space;
    hp_t        enemy_hit_dmg, army_hit_dmg;
    logic       enemy_spawn, army_spawn;
    unit_kind_t enemy_kind, army_kind;

    // --------------------------------------------------
    // the two lanes
    unit_roster #(.NUM_SLOTS(NUM_SLOTS), .IS_ARMY(1'b0)) enemy_roster (
        .clk_25MHz, .rst, .start, .scan_start,
        .spawn(enemy_spawn), .spawn_kind(enemy_kind),
        .opp_front_pos(army_front_pos), .opp_front_valid(army_front_valid),
        .hit_apply, .hit_dmg(enemy_hit_dmg),
        .scan_done(enemy_done), .strikes(enemy_strikes),
        .front_pos(enemy_front_pos), .front_valid(enemy_front_valid),
        .has_space(enemy_space)
    );

    unit_roster #(.NUM_SLOTS(NUM_SLOTS), .IS_ARMY(1'b1)) army_roster (
        .clk_25MHz, .rst, .start, .scan_start,
        .spawn(army_spawn), .spawn_kind(army_kind),
        .opp_front_pos(enemy_front_pos), .opp_front_valid(enemy_front_valid),
        .hit_apply, .hit_dmg(army_hit_dmg),
        .scan_done(army_done), .strikes(army_strikes),
        .front_pos(army_front_pos), .front_valid(army_front_valid),
        .has_space(army_space)
    );

    battle_referee referee0 (
        .clk_25MHz, .rst, .start, .tick,
        .enemy_done, .army_done, .enemy_strikes, .army_strikes,
        .tick_ok, .scan_start, .enemy_hit_dmg, .army_hit_dmg, .hit_apply,
        .tower_hp_enemy, .tower_hp_army, .game_win, .game_lose
    );

    treasury treasury0 (
        .clk_25MHz, .rst, .start, .tick_ok,
        .buy, .buy_kind, .upgrade, .army_space,
        .money, .purse_level, .can_upgrade, .army_spawn, .army_kind
    );

    wave_scheduler waves0 (
        .clk_25MHz, .rst, .start, .tick_ok, .enemy_space,
        .enemy_spawn, .enemy_kind
    );

endmodule

/* design/wave_scheduler.sv */
`timescale 1ns/100ps

module wave_scheduler (
    input  logic                   clk_25MHz,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   tick_ok,
    input  logic                   enemy_space,
    output logic                   enemy_spawn,
    output battle_pkg::unit_kind_t enemy_kind
);
    import battle_pkg::*;

    tick_cnt_t  game_time;
    logic [3:0] wave_idx;   // one past the table means done
    wave_t      entry;

    assign entry = wave_entry(wave_idx[2:0]);

    always_ff @(posedge clk_25MHz) begin
        if (rst || start) begin
            game_time   <= '0;
            wave_idx    <= '0;
            enemy_spawn <= 1'b0;
        end else begin
            enemy_spawn <= 1'b0;
            if (tick_ok) begin
                game_time <= game_time + 1'b1;
                // a full lane holds the entry back until a slot frees up
                if (wave_idx < 4'(WAVE_LEN) && entry.at <= game_time && enemy_space) begin
                    enemy_spawn <= 1'b1;
                    enemy_kind  <= entry.kind;
                    wave_idx    <= wave_idx + 1'b1;
                end
            end
        end
    end

endmodule

/* design/treasury.sv */
`timescale 1ns/100ps

module treasury (
    input  logic                     clk_25MHz,
    input  logic                     rst,
    input  logic                     start,
    input  logic                     tick_ok,
    input  logic                     buy,
    input  battle_pkg::unit_kind_t   buy_kind,
    input  logic                     upgrade,
    input  logic                     army_space,
    output battle_pkg::money_t       money,
    output battle_pkg::purse_level_t purse_level,
    output logic                     can_upgrade,
    output logic                     army_spawn,
    output battle_pkg::unit_kind_t   army_kind
);
    import battle_pkg::*;

    logic         buy_req, up_req;
    unit_kind_t   buy_kind_q;
    logic         buy_ok, up_ok;
    money_t       after_buy, after_up, new_money;
    purse_level_t new_level;
    logic [15:0]  with_income;

    assign can_upgrade = (money >= purse_need(purse_level));

    // --------------------------------------------------
    // purchase, then upgrade, then income
    always_comb begin
        buy_ok      = buy_req && army_space && (money >= army_cost(buy_kind_q));
        after_buy   = buy_ok ? money - army_cost(buy_kind_q) : money;
        up_ok       = up_req && (purse_level != 3'd7)
                      && (after_buy >= purse_need(purse_level));
        after_up    = up_ok ? after_buy - purse_need(purse_level) : after_buy;
        new_level   = up_ok ? purse_level + 1'b1 : purse_level;
        with_income = 16'(after_up) + 16'(purse_income(new_level));
        new_money   = (with_income > 16'(purse_max(new_level))) ?
                      purse_max(new_level) : with_income[14:0];
    end

    always_ff @(posedge clk_25MHz) begin
        if (rst || start) begin
            money       <= '0;
            purse_level <= '0;
            buy_req     <= 1'b0;
            up_req      <= 1'b0;
            army_spawn  <= 1'b0;
        end else begin
            army_spawn <= 1'b0;
            // requests wait for the next tick, a pulse on the tick itself waits for the one after
            buy_req <= buy || (buy_req && !tick_ok);
            up_req  <= upgrade || (up_req && !tick_ok);
            if (buy)
                buy_kind_q <= buy_kind;
            if (tick_ok) begin
                money       <= new_money;
                purse_level <= new_level;
                army_spawn  <= buy_ok;
                army_kind   <= buy_kind_q;
            end
        end
    end

endmodule

/* design/battle_referee.sv */
`timescale 1ns/100ps

module battle_referee (
    input  logic                clk_25MHz,
    input  logic                rst,
    input  logic                start,
    input  logic                tick,
    input  logic                enemy_done,
    input  logic                army_done,
    input  battle_pkg::strike_t enemy_strikes,
    input  battle_pkg::strike_t army_strikes,
    output logic                tick_ok,
    output logic                scan_start,
    output battle_pkg::hp_t     enemy_hit_dmg,
    output battle_pkg::hp_t     army_hit_dmg,
    output logic                hit_apply,
    output battle_pkg::hp_t     tower_hp_enemy,
    output battle_pkg::hp_t     tower_hp_army,
    output logic                game_win,
    output logic                game_lose
);
    import battle_pkg::*;

    typedef enum logic [1:0] {IDLE, SETTLE, SCAN, APPLY} ref_state_t;

    ref_state_t state;

    function automatic hp_t hit_tower(input hp_t hp, input hp_t dmg);
        return (dmg >= hp) ? '0 : hp - dmg;
    endfunction

    assign game_win  = (tower_hp_enemy == '0);
    assign game_lose = (tower_hp_army == '0);
    assign tick_ok   = tick && (state == IDLE) && !game_win && !game_lose;

    always_ff @(posedge clk_25MHz) begin
        if (rst || start) begin
            state          <= IDLE;
            scan_start     <= 1'b0;
            hit_apply      <= 1'b0;
            tower_hp_enemy <= TOWER_HP_INIT;
            tower_hp_army  <= TOWER_HP_INIT;
        end else begin
            scan_start <= 1'b0;
            hit_apply  <= 1'b0;
            case (state)
                IDLE:   if (tick_ok) state <= SETTLE;
                SETTLE: begin   // treasury and spawns land here
                    scan_start <= 1'b1;
                    state      <= SCAN;
                end
                SCAN: begin
                    if (enemy_done && army_done) begin
                        tower_hp_enemy <= hit_tower(tower_hp_enemy, army_strikes.tower);
                        tower_hp_army  <= hit_tower(tower_hp_army, enemy_strikes.tower);
                        enemy_hit_dmg  <= army_strikes.front;   // crossed over
                        army_hit_dmg   <= enemy_strikes.front;
                        hit_apply      <= enemy_strikes.any || army_strikes.any;
                        state          <= APPLY;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* design/unit_roster.sv */
`timescale 1ns/100ps

module unit_roster #(
    parameter int NUM_SLOTS = 8,
    parameter bit IS_ARMY   = 1'b0
) (
    input  logic                   clk_25MHz,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   scan_start,
    input  logic                   spawn,
    input  battle_pkg::unit_kind_t spawn_kind,
    input  battle_pkg::pos_t       opp_front_pos,
    input  logic                   opp_front_valid,
    input  logic                   hit_apply,
    input  battle_pkg::hp_t        hit_dmg,
    output logic                   scan_done,
    output battle_pkg::strike_t    strikes,
    output battle_pkg::pos_t       front_pos,
    output logic                   front_valid,
    output logic                   has_space
);
    import battle_pkg::*;

    localparam slot_idx_t LAST = slot_idx_t'(NUM_SLOTS - 1);

    unit_t       slots [NUM_SLOTS];
    slot_idx_t   scan_idx, cur_idx, front_idx, free_idx;
    logic        scanning, hp_upd;
    unit_t       cur, cur_next;
    unit_stats_t cur_st, spawn_st;
    logic [10:0] lead;
    logic        opp_in, tower_in;
    strike_t     acc;

    // --------------------------------------------------
    // front unit and lowest free slot
    always_comb begin
        unit_stats_t st;
        pos_t        key;
        front_valid = 1'b0;
        front_pos   = '0;
        front_idx   = '0;
        has_space   = 1'b0;
        free_idx    = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (!slots[i].alive) begin
                has_space = 1'b1;
                free_idx  = slot_idx_t'(i);
            end
        end
        for (int i = 0; i < NUM_SLOTS; i++) begin
            st  = stats_of(slots[i].kind, IS_ARMY);
            // enemies face right, so their front edge is pos + width
            key = IS_ARMY ? slots[i].pos : slots[i].pos + pos_t'(st.width);
            if (slots[i].alive && (!front_valid ||
                    (IS_ARMY ? key < front_pos : key > front_pos))) begin
                front_valid = 1'b1;
                front_pos   = key;
                front_idx   = slot_idx_t'(i);
            end
        end
    end

    // --------------------------------------------------
    // one slot per clock during a scan
    assign cur_idx  = scan_start ? '0 : scan_idx;
    assign cur      = slots[cur_idx];
    assign cur_st   = stats_of(cur.kind, IS_ARMY);
    assign spawn_st = stats_of(spawn_kind, IS_ARMY);
    assign lead     = 11'(cur.pos) + 11'(cur_st.width) + 11'(cur_st.range);

    always_comb begin
        if (IS_ARMY) begin
            opp_in   = 11'(opp_front_pos) + 11'(cur_st.range) >= 11'(cur.pos);
            tower_in = 11'(TOWER_E_X) + 11'(cur_st.range) >= 11'(cur.pos);
        end else begin
            opp_in   = lead >= 11'(opp_front_pos);
            tower_in = lead >= 11'(TOWER_A_X);
        end
        opp_in = opp_in && opp_front_valid;
    end

    always_comb begin
        cur_next = cur;
        acc      = scan_start ? '0 : strikes;
        if (cur.alive) begin
            case (cur.state)
                MOVE: begin
                    if (opp_in || tower_in) begin
                        cur_next.state = WIND_UP;
                        cur_next.phase = '0;
                    end else if (IS_ARMY) begin
                        cur_next.pos = cur.pos - pos_t'(cur_st.speed);
                    end else begin
                        cur_next.pos = cur.pos + pos_t'(cur_st.speed);
                    end
                end
                WIND_UP, RECOVER: begin
                    if (cur.phase == cur_st.cooldown) begin
                        cur_next.state = (cur.state == WIND_UP) ? STRIKE : MOVE;
                        cur_next.phase = '0;
                    end else begin
                        cur_next.phase = cur.phase + 1'b1;
                    end
                end
                default: begin  // STRIKE
                    if (opp_in) begin
                        acc.front = acc.front + cur_st.attack;
                        acc.any   = 1'b1;
                    end else if (tower_in) begin
                        acc.tower = acc.tower + cur_st.attack;
                        acc.any   = 1'b1;
                    end
                    cur_next.state = RECOVER;
                end
            endcase
        end
    end

    always_ff @(posedge clk_25MHz) begin
        if (rst || start) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                slots[i] <= '0;
            end
            scan_idx  <= '0;
            scanning  <= 1'b0;
            scan_done <= 1'b0;
            strikes   <= '0;
            hp_upd    <= 1'b0;
        end else begin
            scan_done <= 1'b0;
            hp_upd    <= hit_apply;
            if (spawn && has_space) begin
                slots[free_idx] <= '{alive: 1'b1, kind: spawn_kind,
                                     pos: IS_ARMY ? ARMY_SPAWN_X : ENEMY_SPAWN_X,
                                     hp: spawn_st.hp, state: MOVE, phase: '0, pend: '0};
            end
            if (scan_start || scanning) begin
                slots[cur_idx] <= cur_next;
                strikes        <= acc;
                scan_idx       <= cur_idx + 1'b1;
                scanning       <= (cur_idx != LAST);
                scan_done      <= (cur_idx == LAST);
            end
            if (hit_apply && front_valid) begin
                slots[front_idx].pend <= slots[front_idx].pend + hit_dmg;
            end
            if (hp_upd) begin   // all slots at once
                for (int i = 0; i < NUM_SLOTS; i++) begin
                    if (slots[i].alive) begin
                        if (slots[i].pend >= slots[i].hp)
                            slots[i].alive <= 1'b0;
                        else
                            slots[i].hp <= slots[i].hp - slots[i].pend;
                        slots[i].pend <= '0;
                    end
                end
            end
        end
    end

endmodule

/* design/battle_pkg.sv */
package battle_pkg;

    typedef logic [9:0]  pos_t;
    typedef logic [11:0] hp_t;
    typedef logic [14:0] money_t;
    typedef logic [1:0]  unit_kind_t;
    typedef logic [2:0]  purse_level_t;
    typedef logic [3:0]  phase_cnt_t;
    typedef logic [2:0]  slot_idx_t;
    typedef logic [11:0] tick_cnt_t;

    typedef enum logic [1:0] {MOVE, WIND_UP, STRIKE, RECOVER} unit_state_t;

    typedef struct packed {
        logic        alive;
        unit_kind_t  kind;
        pos_t        pos;
        hp_t         hp;
        unit_state_t state;
        phase_cnt_t  phase;
        hp_t         pend;     // damage waiting for the hp update
    } unit_t;

    typedef struct packed {
        hp_t        hp;
        hp_t        attack;
        logic [3:0] cooldown;
        logic [4:0] speed;
        logic [7:0] range;
        logic [4:0] width;
    } unit_stats_t;

    typedef struct packed {
        hp_t  front;
        hp_t  tower;
        logic any;
    } strike_t;

    typedef struct packed {
        tick_cnt_t  at;
        unit_kind_t kind;
    } wave_t;

    localparam int   WAVE_LEN      = 8;
    localparam hp_t  TOWER_HP_INIT = 12'd4000;
    localparam pos_t ENEMY_SPAWN_X = 10'd10;
    localparam pos_t ARMY_SPAWN_X  = 10'd570;
    localparam pos_t TOWER_E_X     = 10'd70;
    localparam pos_t TOWER_A_X     = 10'd570;

    // --------------------------------------------------
    // tables

    // fields: hp, attack, cooldown, speed, range, width
    function automatic unit_stats_t stats_of(input unit_kind_t kind, input logic army);
        if (army) begin
            case (kind)
                2'd0:    return '{12'd250, 12'd50, 4'd3, 5'd18, 8'd20, 5'd16};
                2'd1:    return '{12'd500, 12'd70, 4'd4, 5'd14, 8'd24, 5'd20};
                2'd2:    return '{12'd180, 12'd100, 4'd2, 5'd22, 8'd80, 5'd14};
                default: return '{12'd1000, 12'd140, 4'd6, 5'd10, 8'd30, 5'd26};
            endcase
        end
        case (kind)
            2'd0:    return '{12'd300, 12'd40, 4'd3, 5'd20, 8'd20, 5'd16};
            2'd1:    return '{12'd600, 12'd60, 4'd4, 5'd12, 8'd24, 5'd20};
            2'd2:    return '{12'd200, 12'd90, 4'd2, 5'd24, 8'd60, 5'd14};
            default: return '{12'd1200, 12'd120, 4'd6, 5'd8, 8'd30, 5'd28};
        endcase
    endfunction

    function automatic money_t army_cost(input unit_kind_t kind);
        case (kind)
            2'd0:    return 15'd50;
            2'd1:    return 15'd100;
            2'd2:    return 15'd150;
            default: return 15'd300;
        endcase
    endfunction

    function automatic money_t purse_need(input purse_level_t level);
        // top level can never be afforded
        return (level == 3'd7) ? 15'h7fff : 15'd60 + 15'(level) * 15'd50;
    endfunction

    function automatic money_t purse_max(input purse_level_t level);
        return 15'd200 + 15'(level) * 15'd100;
    endfunction

    function automatic money_t purse_income(input purse_level_t level);
        return 15'd5 + 15'(level) * 15'd3;
    endfunction

    function automatic wave_t wave_entry(input logic [2:0] idx);
        case (idx)
            3'd0:    return '{12'd0, 2'd0};
            3'd1:    return '{12'd6, 2'd0};
            3'd2:    return '{12'd12, 2'd1};
            3'd3:    return '{12'd18, 2'd0};
            3'd4:    return '{12'd26, 2'd2};
            3'd5:    return '{12'd34, 2'd1};
            3'd6:    return '{12'd42, 2'd3};
            default: return '{12'd50, 2'd2};
        endcase
    endfunction

endpackage
